// ==== src/wbx_pkg.sv ====
package wbx_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Age tag, wraps; compared by signed difference
  localparam int TAG_W = 8;

  // One request waiting for a slave
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic              we;
    logic [TAG_W-1:0]  tag;
  } wbx_req_t;

  // One response waiting for a master
  typedef struct packed {
    logic [DATA_W-1:0] dat;
  } wbx_rsp_t;

  // Destination of an accepted request
  typedef enum logic [1:0] {
    ROUTE_S0  = 2'd0,
    ROUTE_S1  = 2'd1,
    ROUTE_ERR = 2'd2
  } wbx_route_t;

endpackage

// ==== src/wbx_fifo.sv ====
`timescale 1ns/1ps

module wbx_fifo #(
  parameter int  FIFO_AW   = 2,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int DEPTH = 1 << FIFO_AW;

  payload_t         mem [DEPTH];
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic             wr_en;
  logic             rd_en;

  // Extra pointer bit tells full from empty
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

  assign wr_en = push_i && !full_o;
  assign rd_en = pop_i && !empty_o;

  // Head is always visible
  assign data_o = mem[rd_ptr[FIFO_AW-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= data_i;
    end
  end

endmodule

// ==== src/wbx_master_port.sv ====
`timescale 1ns/1ps

module wbx_master_port
  import wbx_pkg::*;
#(
  parameter int                FIFO_AW = 2,
  parameter logic [ADDR_W-1:0] S0_BASE = 32'h0000_0000,
  parameter logic [ADDR_W-1:0] S0_MASK = 32'hFFFF_F000,
  parameter logic [ADDR_W-1:0] S1_BASE = 32'h0000_1000,
  parameter logic [ADDR_W-1:0] S1_MASK = 32'hFFFF_F000
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ADDR_W-1:0] m_addr_i,
  input  logic [DATA_W-1:0] m_dat_i,
  input  logic [SEL_W-1:0]  m_sel_i,
  input  logic              m_cyc_i,
  input  logic              m_stb_i,
  input  logic              m_we_i,
  output logic [DATA_W-1:0] m_dat_o,
  output logic              m_stall_o,
  output logic              m_ack_o,
  output logic              m_err_o,
  input  logic [TAG_W-1:0]  time_tag_i,
  output wbx_req_t          req_0_o,
  output logic              req_0_empty_o,
  input  logic              req_0_pop_i,
  output wbx_req_t          req_1_o,
  output logic              req_1_empty_o,
  input  logic              req_1_pop_i,
  input  wbx_rsp_t          rsp_0_i,
  input  logic              rsp_0_empty_i,
  output logic              rsp_0_pop_o,
  input  wbx_rsp_t          rsp_1_i,
  input  logic              rsp_1_empty_i,
  output logic              rsp_1_pop_o
);

  wbx_route_t route;
  wbx_route_t route_head;
  wbx_req_t   req;
  logic       req_0_full;
  logic       req_1_full;
  logic       route_full;
  logic       route_empty;
  logic       accept;

  // Address decode, slave 0 wins on overlap
  always_comb begin
    if ((m_addr_i & S0_MASK) == (S0_BASE & S0_MASK)) begin
      route = ROUTE_S0;
    end else if ((m_addr_i & S1_MASK) == (S1_BASE & S1_MASK)) begin
      route = ROUTE_S1;
    end else begin
      route = ROUTE_ERR;
    end
  end

  assign m_stall_o = route_full ||
                     (route == ROUTE_S0 && req_0_full) ||
                     (route == ROUTE_S1 && req_1_full);

  assign accept = m_cyc_i && m_stb_i && !m_stall_o;

  assign req = '{addr: m_addr_i, dat: m_dat_i, sel: m_sel_i, we: m_we_i, tag: time_tag_i};

  wbx_fifo #(.FIFO_AW(FIFO_AW), .payload_t(wbx_req_t)) req_0_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept && route == ROUTE_S0),
    .data_i  (req),
    .pop_i   (req_0_pop_i),
    .data_o  (req_0_o),
    .empty_o (req_0_empty_o),
    .full_o  (req_0_full)
  );

  wbx_fifo #(.FIFO_AW(FIFO_AW), .payload_t(wbx_req_t)) req_1_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept && route == ROUTE_S1),
    .data_i  (req),
    .pop_i   (req_1_pop_i),
    .data_o  (req_1_o),
    .empty_o (req_1_empty_o),
    .full_o  (req_1_full)
  );

  // Issue order of every accepted request, errors included
  wbx_fifo #(.FIFO_AW(FIFO_AW), .payload_t(wbx_route_t)) route_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept),
    .data_i  (route),
    .pop_i   (m_ack_o || m_err_o),
    .data_o  (route_head),
    .empty_o (route_empty),
    .full_o  (route_full)
  );

  // Oldest route picks the response source
  always_comb begin
    m_ack_o     = 1'b0;
    m_err_o     = 1'b0;
    rsp_0_pop_o = 1'b0;
    rsp_1_pop_o = 1'b0;
    if (!route_empty) begin
      case (route_head)
        ROUTE_S0: begin
          m_ack_o     = !rsp_0_empty_i;
          rsp_0_pop_o = !rsp_0_empty_i;
        end
        ROUTE_S1: begin
          m_ack_o     = !rsp_1_empty_i;
          rsp_1_pop_o = !rsp_1_empty_i;
        end
        default: m_err_o = 1'b1;
      endcase
    end
  end

  assign m_dat_o = (route_head == ROUTE_S1) ? rsp_1_i.dat : rsp_0_i.dat;

endmodule

// ==== src/wbx_slave_port.sv ====
`timescale 1ns/1ps

module wbx_slave_port
  import wbx_pkg::*;
#(
  parameter int FIFO_AW = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  output logic [ADDR_W-1:0] s_addr_o,
  output logic [DATA_W-1:0] s_dat_o,
  output logic [SEL_W-1:0]  s_sel_o,
  output logic              s_cyc_o,
  output logic              s_stb_o,
  output logic              s_we_o,
  input  logic [DATA_W-1:0] s_dat_i,
  input  logic              s_stall_i,
  input  logic              s_ack_i,
  input  wbx_req_t          req_0_i,
  input  logic              req_0_empty_i,
  output logic              req_0_pop_o,
  output wbx_rsp_t          rsp_0_o,
  output logic              rsp_0_empty_o,
  input  logic              rsp_0_pop_i,
  input  wbx_req_t          req_1_i,
  input  logic              req_1_empty_i,
  output logic              req_1_pop_o,
  output wbx_rsp_t          rsp_1_o,
  output logic              rsp_1_empty_o,
  input  logic              rsp_1_pop_i
);

  localparam logic [FIFO_AW:0] CNT_MAX = {1'b1, {FIFO_AW{1'b0}}};

  wbx_req_t                bus_q;
  wbx_rsp_t                rsp;
  logic                    bus_own;
  logic                    own_head;
  logic                    own_empty;
  logic                    pick_1;
  logic                    issue;
  logic                    s_accept;
  logic [1:0]              elig;
  logic [1:0]              credit_ok;
  logic [1:0]              cnt_inc;
  logic [1:0]              cnt_dec;
  logic [FIFO_AW:0]        out_cnt [2];
  logic signed [TAG_W-1:0] tag_diff;

  // Responses owed to each master, issued but not yet taken by it
  assign cnt_inc = {issue && pick_1, issue && !pick_1};
  assign cnt_dec = {rsp_1_pop_i, rsp_0_pop_i};

  for (genvar m = 0; m < 2; m++) begin : g_cnt
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        out_cnt[m] <= '0;
      end else if (cnt_inc[m] != cnt_dec[m]) begin
        out_cnt[m] <= cnt_inc[m] ? out_cnt[m] + 1'b1 : out_cnt[m] - 1'b1;
      end
    end
    assign credit_ok[m] = (out_cnt[m] != CNT_MAX);
  end

  assign elig = {!req_1_empty_i && credit_ok[1], !req_0_empty_i && credit_ok[0]};

  // Wrap-aware age, ties go to master 0
  assign tag_diff = req_0_i.tag - req_1_i.tag;

  always_comb begin
    if (elig == 2'b11) begin
      pick_1 = (tag_diff > 0);
    end else begin
      pick_1 = elig[1];
    end
  end

  // New request only onto an idle strobe
  assign issue    = !s_stb_o && (elig != 2'b00);
  assign s_accept = s_stb_o && !s_stall_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_stb_o <= 1'b0;
    end else if (issue) begin
      s_stb_o <= 1'b1;
    end else if (s_accept) begin
      s_stb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      bus_q   <= pick_1 ? req_1_i : req_0_i;
      bus_own <= pick_1;
    end
  end

  assign s_addr_o = bus_q.addr;
  assign s_dat_o  = bus_q.dat;
  assign s_sel_o  = bus_q.sel;
  assign s_we_o   = bus_q.we;
  assign s_cyc_o  = s_stb_o || !own_empty;

  // Queue entry leaves only once the slave takes it
  assign req_0_pop_o = s_accept && !bus_own;
  assign req_1_pop_o = s_accept && bus_own;

  // Owners of accepted requests, in ack order
  wbx_fifo #(.FIFO_AW(FIFO_AW + 1), .payload_t(logic)) own_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (s_accept),
    .data_i  (bus_own),
    .pop_i   (s_ack_i),
    .data_o  (own_head),
    .empty_o (own_empty),
    .full_o  ()
  );

  assign rsp = '{dat: s_dat_i};

  wbx_fifo #(.FIFO_AW(FIFO_AW), .payload_t(wbx_rsp_t)) rsp_0_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (s_ack_i && !own_head),
    .data_i  (rsp),
    .pop_i   (rsp_0_pop_i),
    .data_o  (rsp_0_o),
    .empty_o (rsp_0_empty_o),
    .full_o  ()
  );

  wbx_fifo #(.FIFO_AW(FIFO_AW), .payload_t(wbx_rsp_t)) rsp_1_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (s_ack_i && own_head),
    .data_i  (rsp),
    .pop_i   (rsp_1_pop_i),
    .data_o  (rsp_1_o),
    .empty_o (rsp_1_empty_o),
    .full_o  ()
  );

endmodule

// ==== src/wbx_top.sv ====
`timescale 1ns/1ps

module wbx_top
  import wbx_pkg::*;
#(
  parameter int                FIFO_AW = 2,
  parameter logic [ADDR_W-1:0] S0_BASE = 32'h0000_0000,
  parameter logic [ADDR_W-1:0] S0_MASK = 32'hFFFF_F000,
  parameter logic [ADDR_W-1:0] S1_BASE = 32'h0000_1000,
  parameter logic [ADDR_W-1:0] S1_MASK = 32'hFFFF_F000
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ADDR_W-1:0] m0_addr_i,
  input  logic [DATA_W-1:0] m0_dat_i,
  input  logic [SEL_W-1:0]  m0_sel_i,
  input  logic              m0_cyc_i,
  input  logic              m0_stb_i,
  input  logic              m0_we_i,
  output logic [DATA_W-1:0] m0_dat_o,
  output logic              m0_stall_o,
  output logic              m0_ack_o,
  output logic              m0_err_o,
  input  logic [ADDR_W-1:0] m1_addr_i,
  input  logic [DATA_W-1:0] m1_dat_i,
  input  logic [SEL_W-1:0]  m1_sel_i,
  input  logic              m1_cyc_i,
  input  logic              m1_stb_i,
  input  logic              m1_we_i,
  output logic [DATA_W-1:0] m1_dat_o,
  output logic              m1_stall_o,
  output logic              m1_ack_o,
  output logic              m1_err_o,
  output logic [ADDR_W-1:0] s0_addr_o,
  output logic [DATA_W-1:0] s0_dat_o,
  output logic [SEL_W-1:0]  s0_sel_o,
  output logic              s0_cyc_o,
  output logic              s0_stb_o,
  output logic              s0_we_o,
  input  logic [DATA_W-1:0] s0_dat_i,
  input  logic              s0_stall_i,
  input  logic              s0_ack_i,
  output logic [ADDR_W-1:0] s1_addr_o,
  output logic [DATA_W-1:0] s1_dat_o,
  output logic [SEL_W-1:0]  s1_sel_o,
  output logic              s1_cyc_o,
  output logic              s1_stb_o,
  output logic              s1_we_o,
  input  logic [DATA_W-1:0] s1_dat_i,
  input  logic              s1_stall_i,
  input  logic              s1_ack_i
);

  logic [TAG_W-1:0] time_tag;
  wbx_req_t         m0_s0_req, m0_s1_req, m1_s0_req, m1_s1_req;
  logic             m0_s0_empty, m0_s1_empty, m1_s0_empty, m1_s1_empty;
  logic             m0_s0_pop, m0_s1_pop, m1_s0_pop, m1_s1_pop;
  wbx_rsp_t         s0_m0_rsp, s0_m1_rsp, s1_m0_rsp, s1_m1_rsp;
  logic             s0_m0_empty, s0_m1_empty, s1_m0_empty, s1_m1_empty;
  logic             s0_m0_pop, s0_m1_pop, s1_m0_pop, s1_m1_pop;

  // One step per accepting cycle, even when both masters are accepted
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      time_tag <= '0;
    end else if ((m0_cyc_i && m0_stb_i && !m0_stall_o) ||
                 (m1_cyc_i && m1_stb_i && !m1_stall_o)) begin
      time_tag <= time_tag + 1'b1;
    end
  end

  wbx_master_port #(
    .FIFO_AW(FIFO_AW), .S0_BASE(S0_BASE), .S0_MASK(S0_MASK),
    .S1_BASE(S1_BASE), .S1_MASK(S1_MASK)
  ) m0_port (
    .clk_i(clk_i), .rst_i(rst_i), .time_tag_i(time_tag),
    .m_addr_i(m0_addr_i), .m_dat_i(m0_dat_i), .m_sel_i(m0_sel_i),
    .m_cyc_i(m0_cyc_i), .m_stb_i(m0_stb_i), .m_we_i(m0_we_i),
    .m_dat_o(m0_dat_o), .m_stall_o(m0_stall_o), .m_ack_o(m0_ack_o), .m_err_o(m0_err_o),
    .req_0_o(m0_s0_req), .req_0_empty_o(m0_s0_empty), .req_0_pop_i(m0_s0_pop),
    .req_1_o(m0_s1_req), .req_1_empty_o(m0_s1_empty), .req_1_pop_i(m0_s1_pop),
    .rsp_0_i(s0_m0_rsp), .rsp_0_empty_i(s0_m0_empty), .rsp_0_pop_o(s0_m0_pop),
    .rsp_1_i(s1_m0_rsp), .rsp_1_empty_i(s1_m0_empty), .rsp_1_pop_o(s1_m0_pop)
  );

  wbx_master_port #(
    .FIFO_AW(FIFO_AW), .S0_BASE(S0_BASE), .S0_MASK(S0_MASK),
    .S1_BASE(S1_BASE), .S1_MASK(S1_MASK)
  ) m1_port (
    .clk_i(clk_i), .rst_i(rst_i), .time_tag_i(time_tag),
    .m_addr_i(m1_addr_i), .m_dat_i(m1_dat_i), .m_sel_i(m1_sel_i),
    .m_cyc_i(m1_cyc_i), .m_stb_i(m1_stb_i), .m_we_i(m1_we_i),
    .m_dat_o(m1_dat_o), .m_stall_o(m1_stall_o), .m_ack_o(m1_ack_o), .m_err_o(m1_err_o),
    .req_0_o(m1_s0_req), .req_0_empty_o(m1_s0_empty), .req_0_pop_i(m1_s0_pop),
    .req_1_o(m1_s1_req), .req_1_empty_o(m1_s1_empty), .req_1_pop_i(m1_s1_pop),
    .rsp_0_i(s0_m1_rsp), .rsp_0_empty_i(s0_m1_empty), .rsp_0_pop_o(s0_m1_pop),
    .rsp_1_i(s1_m1_rsp), .rsp_1_empty_i(s1_m1_empty), .rsp_1_pop_o(s1_m1_pop)
  );

  wbx_slave_port #(.FIFO_AW(FIFO_AW)) s0_port (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_addr_o(s0_addr_o), .s_dat_o(s0_dat_o), .s_sel_o(s0_sel_o),
    .s_cyc_o(s0_cyc_o), .s_stb_o(s0_stb_o), .s_we_o(s0_we_o),
    .s_dat_i(s0_dat_i), .s_stall_i(s0_stall_i), .s_ack_i(s0_ack_i),
    .req_0_i(m0_s0_req), .req_0_empty_i(m0_s0_empty), .req_0_pop_o(m0_s0_pop),
    .rsp_0_o(s0_m0_rsp), .rsp_0_empty_o(s0_m0_empty), .rsp_0_pop_i(s0_m0_pop),
    .req_1_i(m1_s0_req), .req_1_empty_i(m1_s0_empty), .req_1_pop_o(m1_s0_pop),
    .rsp_1_o(s0_m1_rsp), .rsp_1_empty_o(s0_m1_empty), .rsp_1_pop_i(s0_m1_pop)
  );

  wbx_slave_port #(.FIFO_AW(FIFO_AW)) s1_port (
    .clk_i(clk_i), .rst_i(rst_i),
    .s_addr_o(s1_addr_o), .s_dat_o(s1_dat_o), .s_sel_o(s1_sel_o),
    .s_cyc_o(s1_cyc_o), .s_stb_o(s1_stb_o), .s_we_o(s1_we_o),
    .s_dat_i(s1_dat_i), .s_stall_i(s1_stall_i), .s_ack_i(s1_ack_i),
    .req_0_i(m0_s1_req), .req_0_empty_i(m0_s1_empty), .req_0_pop_o(m0_s1_pop),
    .rsp_0_o(s1_m0_rsp), .rsp_0_empty_o(s1_m0_empty), .rsp_0_pop_i(s1_m0_pop),
    .req_1_i(m1_s1_req), .req_1_empty_i(m1_s1_empty), .req_1_pop_o(m1_s1_pop),
    .rsp_1_o(s1_m1_rsp), .rsp_1_empty_o(s1_m1_empty), .rsp_1_pop_i(s1_m1_pop)
  );

endmodule

// ==== testbench/wbx_tb_clk.sv ====
`timescale 1ns/1ps

module wbx_tb_clk #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

// ==== testbench/wbx_tb_mem.sv ====
`timescale 1ns/1ps

module wbx_tb_mem
  import wbx_pkg::*;
#(
  parameter logic [DATA_W-1:0] FILL = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]  sel_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic              hold_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              stall_o,
  output logic              ack_o,
  output logic [31:0]       xfer_o
);

  logic [DATA_W-1:0] mem [1024];
  logic [DATA_W-1:0] rsp_q [$];
  logic              stall;
  int                delay;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = FILL ^ (i * 32'h0001_0003);
    end
    dat_o   = '0;
    stall_o = 1'b0;
    ack_o   = 1'b0;
    xfer_o  = '0;
    delay   = 0;
  end

  // Outputs move on the falling edge, the crossbar samples on the rising one
  always @(negedge clk_i) begin
    ack_o <= 1'b0;
    if (rst_i) begin
      rsp_q.delete();
      stall_o <= 1'b0;
    end else begin
      if (rsp_q.size() != 0) begin
        if (delay == 0) begin
          ack_o <= 1'b1;
          dat_o <= rsp_q.pop_front();
          delay = $urandom_range(3);
        end else begin
          delay--;
        end
      end
      stall = hold_i || ($urandom_range(3) == 0);
      stall_o <= stall;
      // Taken at the coming rising edge, so served right away
      if (cyc_i && stb_i && !stall) begin
        if (we_i) begin
          for (int b = 0; b < SEL_W; b++) begin
            if (sel_i[b]) begin
              mem[addr_i[11:2]][8*b +: 8] = dat_i[8*b +: 8];
            end
          end
          rsp_q.push_back('0);
        end else begin
          rsp_q.push_back(mem[addr_i[11:2]]);
        end
        xfer_o <= xfer_o + 1;
      end
    end
  end

endmodule

// ==== testbench/wbx_assert.sv ====
`timescale 1ns/1ps

module wbx_assert
  import wbx_pkg::*;
(
  input logic                         clk_i,
  input logic                         rst_i,
  input logic                         cyc_i,
  input logic                         stb_i,
  input logic                         stall_i,
  input logic                         ack_i,
  input logic [ADDR_W+DATA_W+SEL_W:0] bus_i,
  input logic [TAG_W-1:0]             bus_tag_i,
  input logic                         own_empty_i,
  input logic                         issue_i,
  input logic [1:0]                   elig_i,
  input logic [TAG_W-1:0]             tag_0_i,
  input logic [TAG_W-1:0]             tag_1_i
);

  int pend;
  int fail_cnt = 0;

  // Requests taken by the slave and still owed an ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend <= 0;
    end else begin
      pend <= pend + int'(stb_i && !stall_i) - int'(ack_i);
    end
  end

  cyc_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (stb_i || pend != 0) |-> cyc_i)
    else begin
      $error("slave cyc low while a request is strobed or awaits an ack");
      fail_cnt++;
    end

  hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i && stall_i |=> stb_i && $stable(bus_i))
    else begin
      $error("slave request changed while stalled");
      fail_cnt++;
    end

  ack_has_owner: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> !own_empty_i)
    else begin
      $error("slave ack with no request outstanding");
      fail_cnt++;
    end

  // Issued tag against both heads it was picked from
  oldest_first: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_i && elig_i == 2'b11 |=>
      $signed(bus_tag_i - $past(tag_0_i)) <= 0 &&
      $signed(bus_tag_i - $past(tag_1_i)) <= 0)
    else begin
      $error("younger request issued ahead of an older one");
      fail_cnt++;
    end

endmodule

bind wbx_slave_port wbx_assert assert_inst (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .cyc_i       (s_cyc_o),
  .stb_i       (s_stb_o),
  .stall_i     (s_stall_i),
  .ack_i       (s_ack_i),
  .bus_i       ({s_addr_o, s_dat_o, s_sel_o, s_we_o}),
  .bus_tag_i   (bus_q.tag),
  .own_empty_i (own_empty),
  .issue_i     (issue),
  .elig_i      (elig),
  .tag_0_i     (req_0_i.tag),
  .tag_1_i     (req_1_i.tag)
);

// ==== testbench/wbx_tb.sv ====
`timescale 1ns/1ps

module wbx_tb
  import wbx_pkg::*;
();

  localparam int          FIFO_AW = 2;
  localparam int          DEPTH   = 1 << FIFO_AW;
  localparam int          HALF    = 512;
  localparam logic [31:0] S0_BASE = 32'h0000_0000;
  localparam logic [31:0] S0_MASK = 32'hFFFF_F000;
  localparam logic [31:0] S1_BASE = 32'h0000_1000;
  localparam logic [31:0] S1_MASK = 32'hFFFF_F000;
  localparam logic [31:0] FILL0   = 32'h5a5a_0000;
  localparam logic [31:0] FILL1   = 32'hc3c3_0000;

  typedef struct packed {
    logic              err;
    logic              rd;
    logic [DATA_W-1:0] dat;
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic [1:0][ADDR_W-1:0] m_addr;
  logic [1:0][DATA_W-1:0] m_wdat;
  logic [1:0][SEL_W-1:0]  m_sel;
  logic [1:0]             m_cyc;
  logic [1:0]             m_stb;
  logic [1:0]             m_we;
  wire  [1:0][DATA_W-1:0] m_rdat;
  wire  [1:0]             m_stall;
  wire  [1:0]             m_ack;
  wire  [1:0]             m_err;
  wire  [1:0][ADDR_W-1:0] s_addr;
  wire  [1:0][DATA_W-1:0] s_wdat;
  wire  [1:0][SEL_W-1:0]  s_sel;
  wire  [1:0]             s_cyc;
  wire  [1:0]             s_stb;
  wire  [1:0]             s_we;
  wire  [1:0][DATA_W-1:0] s_rdat;
  wire  [1:0]             s_stall;
  wire  [1:0]             s_ack;
  wire  [1:0][31:0]       s_xfer;
  logic [1:0]             s_hold;

  logic [DATA_W-1:0] model [2][1024];
  expect_t           exp_q0 [$];
  expect_t           exp_q1 [$];
  int                n_accept [2];
  int                n_valid [2];
  int                n_rsp [2];
  int                errors;
  int                checks;
  int                err_mark;
  int                tests_ok;
  int                tests_bad;
  int                fails_seen;

  wbx_tb_clk clk_gen (.clk_o(clk));

  wbx_top #(
    .FIFO_AW(FIFO_AW), .S0_BASE(S0_BASE), .S0_MASK(S0_MASK),
    .S1_BASE(S1_BASE), .S1_MASK(S1_MASK)
  ) wbx_top_inst (
    .clk_i(clk), .rst_i(rst),
    .m0_addr_i(m_addr[0]), .m0_dat_i(m_wdat[0]), .m0_sel_i(m_sel[0]),
    .m0_cyc_i(m_cyc[0]), .m0_stb_i(m_stb[0]), .m0_we_i(m_we[0]),
    .m0_dat_o(m_rdat[0]), .m0_stall_o(m_stall[0]), .m0_ack_o(m_ack[0]), .m0_err_o(m_err[0]),
    .m1_addr_i(m_addr[1]), .m1_dat_i(m_wdat[1]), .m1_sel_i(m_sel[1]),
    .m1_cyc_i(m_cyc[1]), .m1_stb_i(m_stb[1]), .m1_we_i(m_we[1]),
    .m1_dat_o(m_rdat[1]), .m1_stall_o(m_stall[1]), .m1_ack_o(m_ack[1]), .m1_err_o(m_err[1]),
    .s0_addr_o(s_addr[0]), .s0_dat_o(s_wdat[0]), .s0_sel_o(s_sel[0]),
    .s0_cyc_o(s_cyc[0]), .s0_stb_o(s_stb[0]), .s0_we_o(s_we[0]),
    .s0_dat_i(s_rdat[0]), .s0_stall_i(s_stall[0]), .s0_ack_i(s_ack[0]),
    .s1_addr_o(s_addr[1]), .s1_dat_o(s_wdat[1]), .s1_sel_o(s_sel[1]),
    .s1_cyc_o(s_cyc[1]), .s1_stb_o(s_stb[1]), .s1_we_o(s_we[1]),
    .s1_dat_i(s_rdat[1]), .s1_stall_i(s_stall[1]), .s1_ack_i(s_ack[1])
  );

  wbx_tb_mem #(.FILL(FILL0)) mem_0 (
    .clk_i(clk), .rst_i(rst), .addr_i(s_addr[0]), .dat_i(s_wdat[0]), .sel_i(s_sel[0]),
    .cyc_i(s_cyc[0]), .stb_i(s_stb[0]), .we_i(s_we[0]), .hold_i(s_hold[0]),
    .dat_o(s_rdat[0]), .stall_o(s_stall[0]), .ack_o(s_ack[0]), .xfer_o(s_xfer[0])
  );

  wbx_tb_mem #(.FILL(FILL1)) mem_1 (
    .clk_i(clk), .rst_i(rst), .addr_i(s_addr[1]), .dat_i(s_wdat[1]), .sel_i(s_sel[1]),
    .cyc_i(s_cyc[1]), .stb_i(s_stb[1]), .we_i(s_we[1]), .hold_i(s_hold[1]),
    .dat_o(s_rdat[1]), .stall_o(s_stall[1]), .ack_o(s_ack[1]), .xfer_o(s_xfer[1])
  );

  function automatic int target_of(input logic [ADDR_W-1:0] addr);
    if ((addr & S0_MASK) == (S0_BASE & S0_MASK)) begin
      return 0;
    end
    if ((addr & S1_MASK) == (S1_BASE & S1_MASK)) begin
      return 1;
    end
    return -1;
  endfunction

  // Each master keeps to its own half of a window; s == 2 gives an unmapped address
  function automatic logic [ADDR_W-1:0] rand_addr(input int m, input int s);
    int word;
    word = m * HALF + $urandom_range(15);
    if (s == 0) begin
      return S0_BASE + (word << 2);
    end
    if (s == 1) begin
      return S1_BASE + (word << 2);
    end
    return 32'h0000_2000 + ($urandom_range(1023) << 2);
  endfunction

  function automatic int pending(input int m);
    return (m == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  // Failures of the assertions bound to both slave ports
  function automatic int bound_fails();
    return wbx_top_inst.s0_port.assert_inst.fail_cnt +
           wbx_top_inst.s1_port.assert_inst.fail_cnt;
  endfunction

  task automatic record_request(input int m, input logic [ADDR_W-1:0] addr, input logic we,
                                input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel);
    expect_t e;
    int      s;
    int      idx;
    s   = target_of(addr);
    idx = addr[11:2];
    e   = '0;
    if (s < 0) begin
      e.err = 1'b1;
    end else begin
      n_valid[s]++;
      e.rd  = !we;
      e.dat = model[s][idx];
      for (int b = 0; b < SEL_W; b++) begin
        if (we && sel[b]) begin
          model[s][idx][8*b +: 8] = dat[8*b +: 8];
        end
      end
    end
    if (m == 0) begin
      exp_q0.push_back(e);
    end else begin
      exp_q1.push_back(e);
    end
    n_accept[m]++;
  endtask

  task automatic check_response(input int m);
    expect_t e;
    if (m_ack[m] || m_err[m]) begin
      n_rsp[m]++;
      checks++;
      assert (!(m_ack[m] && m_err[m]) && pending(m) != 0) else begin
        $display("master %0d got a stray or double response at %0t", m, $time);
        errors++;
      end
      if (pending(m) != 0) begin
        if (m == 0) begin
          e = exp_q0.pop_front();
        end else begin
          e = exp_q1.pop_front();
        end
        checks++;
        assert (m_err[m] == e.err) else begin
          $display("mismatch at %0t: master %0d err is %0b, expected %0b", $time, m,
                   m_err[m], e.err);
          errors++;
        end
        checks++;
        assert (!e.rd || m_err[m] || m_rdat[m] == e.dat) else begin
          $display("mismatch at %0t: master %0d read %h, expected %h", $time, m,
                   m_rdat[m], e.dat);
          errors++;
        end
      end
    end
  endtask

  // Responses are state driven, so they are steady on the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_response(0);
      check_response(1);
    end
  end

  // Leaves the request on the bus after acceptance; the next call or an idle follows
  task automatic issue_req(input int m, input logic [ADDR_W-1:0] addr, input logic we,
                           input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                           input int max_wait, input logic may_stall, output logic ok);
    int waited;
    waited = 0;
    @(negedge clk);
    m_addr[m] = addr;
    m_wdat[m] = dat;
    m_sel[m]  = sel;
    m_we[m]   = we;
    m_cyc[m]  = 1'b1;
    m_stb[m]  = 1'b1;
    #1;
    while (m_stall[m] && waited < max_wait) begin
      @(negedge clk);
      #1;
      waited++;
    end
    ok = !m_stall[m];
    if (ok) begin
      record_request(m, addr, we, dat, sel);
    end else begin
      if (!may_stall) begin
        $display("master %0d stalled for more than %0d cycles", m, max_wait);
        errors++;
      end
      @(negedge clk);
      m_cyc[m] = 1'b0;
      m_stb[m] = 1'b0;
    end
  endtask

  task automatic idle_master(input int m);
    @(negedge clk);
    m_cyc[m] = 1'b0;
    m_stb[m] = 1'b0;
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((pending(0) != 0 || pending(1) != 0) && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (pending(0) != 0 || pending(1) != 0) begin
      $display("timeout: responses still missing after %0d cycles", max_cycles);
      errors++;
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < 2; i++) begin
      checks++;
      assert (n_rsp[i] == n_accept[i]) else begin
        $display("mismatch at %0t: master %0d has %0d responses for %0d requests", $time, i,
                 n_rsp[i], n_accept[i]);
        errors++;
      end
      checks++;
      assert (s_xfer[i] == n_valid[i]) else begin
        $display("mismatch at %0t: slave %0d saw %0d transfers, expected %0d", $time, i,
                 s_xfer[i], n_valid[i]);
        errors++;
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    int fails_now;
    fails_now  = bound_fails();
    errors     = errors + fails_now - fails_seen;
    fails_seen = fails_now;
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic run_random(input int m, input int n, input logic with_err);
    logic              ok;
    logic              we;
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < n; i++) begin
      addr = rand_addr(m, $urandom_range(with_err ? 2 : 1));
      we   = $urandom_range(1);
      issue_req(m, addr, we, $urandom, $urandom_range(15), 100, 1'b0, ok);
      if ($urandom_range(3) == 0) begin
        idle_master(m);
      end
    end
    idle_master(m);
  endtask

  initial begin
    logic              ok;
    logic [ADDR_W-1:0] addr;
    int                n_ok;
    void'($urandom(32'hb6af18cd));
    rst        = 1'b1;
    m_addr     = '0;
    m_wdat     = '0;
    m_sel      = '0;
    m_cyc      = '0;
    m_stb      = '0;
    m_we       = '0;
    s_hold     = '0;
    errors     = 0;
    checks     = 0;
    err_mark   = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    fails_seen = 0;
    for (int i = 0; i < 1024; i++) begin
      model[0][i] = FILL0 ^ (i * 32'h0001_0003);
      model[1][i] = FILL1 ^ (i * 32'h0001_0003);
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;

    checks++;
    assert (s_cyc == 2'b00 && s_stb == 2'b00 && m_stall == 2'b00 && m_ack == 2'b00 &&
            m_err == 2'b00) else begin
      $display("mismatch at %0t: bus outputs not idle after reset", $time);
      errors++;
    end
    end_test(1, "reset state");

    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 2; s++) begin
        addr = rand_addr(m, s);
        issue_req(m, addr, 1'b1, $urandom, $urandom_range(15, 1), 100, 1'b0, ok);
        issue_req(m, addr, 1'b0, '0, 4'hf, 100, 1'b0, ok);
        idle_master(m);
        wait_drain(200);
      end
    end
    check_counts();
    end_test(2, "single write and read back");

    fork
      run_random(0, 300, 1'b0);
      run_random(1, 300, 1'b0);
    join
    wait_drain(3000);
    check_counts();
    end_test(3, "random traffic from both masters");

    fork
      run_random(0, 60, 1'b1);
      run_random(1, 60, 1'b1);
    join
    wait_drain(1000);
    check_counts();
    end_test(4, "unmapped addresses among valid requests");

    // Slave 0 stalls until its request queue from master 0 fills
    @(negedge clk);
    s_hold[0] = 1'b1;
    n_ok = 0;
    ok   = 1'b1;
    while (ok && n_ok <= DEPTH) begin
      issue_req(0, rand_addr(0, 0), $urandom_range(1), $urandom, 4'hf, 4, 1'b1, ok);
      if (ok) begin
        n_ok++;
      end
    end
    checks++;
    assert (!ok && n_ok == DEPTH) else begin
      $display("mismatch at %0t: %0d requests accepted before stall, expected %0d", $time,
               n_ok, DEPTH);
      errors++;
    end
    idle_master(0);
    repeat (10) @(negedge clk);
    s_hold[0] = 1'b0;
    wait_drain(500);
    check_counts();
    end_test(5, "long slave stall");

    $display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d", tests_ok, tests_bad,
             checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/wbx_pkg.sv
src/wbx_fifo.sv
src/wbx_master_port.sv
src/wbx_slave_port.sv
src/wbx_top.sv
testbench/wbx_tb_clk.sv
testbench/wbx_tb_mem.sv
testbench/wbx_assert.sv
testbench/wbx_tb.sv

// ==== Bender.yml ====
package:
  name: wbx

sources:
  - files:
      - src/wbx_pkg.sv
      - src/wbx_fifo.sv
      - src/wbx_master_port.sv
      - src/wbx_slave_port.sv
      - src/wbx_top.sv
  - target: test
    files:
      - testbench/wbx_tb_clk.sv
      - testbench/wbx_tb_mem.sv
      - testbench/wbx_assert.sv
      - testbench/wbx_tb.sv
